// ==== test/lcd_golden.mem ====
// columns: op addr data expected limit, all hex
// op 1 write, 2 read (data is the mask), 3 oam lfsr writes (data = count),
// 4 oam check (data = count), 5 wait ly (data), 6 dma done, 7 mode run, 8 irq count
// reset values, STAT has bit 7, lyc match and mode 0
2 40 ff 00 0
2 41 ff 84 0
2 44 ff 00 0
2 46 ff 00 0
2 47 ff fc 0
2 48 ff ff 0
2 49 ff ff 0
2 4b ff 00 0
2 3f ff ff 0
2 4c ff ff 0
// readback
1 42 a5 00 0
2 42 ff a5 0
1 43 5a 00 0
2 43 ff 5a 0
1 45 05 00 0
2 45 ff 05 0
1 47 1b 00 0
2 47 ff 1b 0
1 48 e4 00 0
2 48 ff e4 0
1 49 27 00 0
2 49 ff 27 0
1 4a 3c 00 0
2 4a ff 3c 0
1 4b 07 00 0
2 4b ff 07 0
1 41 78 00 0
2 41 78 78 0
1 41 00 00 0
// LY is read only
1 44 77 00 0
2 44 ff 00 0
// oam with lfsr data, nothing above 0x9f
3 00 10 00 0
4 00 10 00 0
3 98 10 00 0
4 98 10 00 0
4 a0 60 00 0
// lcd on, lyc coincidence on line 5
1 40 91 00 0
5 00 05 00 1000
2 41 04 04 0
5 00 06 00 200
2 41 04 00 0
// mode lengths, vblank is 10 lines
7 00 02 50 400
7 00 03 a0 400
7 00 00 d8 400
7 00 01 11d0 12000
5 00 99 00 12000
2 41 03 01 0
5 00 00 00 200
// irq over one frame, hblank fires on all 154 lines
1 41 40 00 0
8 00 00 01 11250
1 41 10 00 0
8 00 00 01 11250
1 41 08 00 0
8 00 00 9a 11250
1 41 00 00 0
// dma from page c3, cpu writes during it are lost
1 46 c3 00 0
3 00 20 00 0
6 00 00 280 400
2 46 ff c3 0
4 00 a0 00 0
0 00 00 00 0

// ==== project.f ====
common/lcd_pkg.sv
src/lcd_regs.sv
src/lcd_timing.sv
oam/oam_dma.sv
oam/oam_ram.sv
src/lcd_controller.sv
test/lcd_controller_properties.sv
test/lcd_controller_tb.sv

// ==== Bender.yml ====
package:
  name: lcd_controller

sources:
  - common/lcd_pkg.sv
  - src/lcd_regs.sv
  - src/lcd_timing.sv
  - oam/oam_dma.sv
  - oam/oam_ram.sv
  - src/lcd_controller.sv
  - target: test
    files:
      - test/lcd_controller_properties.sv
      - test/lcd_controller_tb.sv

// ==== test/lcd_controller_tb.sv ====
// ------------------------------
// lcd controller testbench: golden script player,
// dma source model and an oam shadow copy
// ------------------------------
`timescale 1ns/1ps

module lcd_controller_tb import lcd_pkg::*; ();

	logic        clk_reg;
	logic        reset;
	logic        cpu_sel_reg;
	logic        cpu_sel_oam;
	byte_t       cpu_addr;
	logic        cpu_wr;
	byte_t       cpu_di;
	byte_t       cpu_do;
	byte_t       dma_data;
	logic        lcd_on;
	lcd_mode_t   mode;
	logic        irq;
	logic        dma_rd;
	logic [15:0] dma_addr;

	// five words per command: op, addr, data, expected, limit
	logic [31:0] script [0:499];
	// expected oam contents, 0xff from 160 up
	byte_t       oam_model [0:255];
	logic [31:0] lfsr;
	int          cycle = 0;
	int          checks;
	int          value_errors;
	int          timeouts;
	int          dma_start_cycle;
	byte_t       dma_page_model;
	logic        dma_pending;
	logic        aborted;

	lcd_controller UUT (
		.clk_reg     (clk_reg),
		.reset       (reset),
		.cpu_sel_reg (cpu_sel_reg),
		.cpu_sel_oam (cpu_sel_oam),
		.cpu_addr    (cpu_addr),
		.cpu_wr      (cpu_wr),
		.cpu_di      (cpu_di),
		.cpu_do      (cpu_do),
		.lcd_on      (lcd_on),
		.mode        (mode),
		.irq         (irq),
		.dma_rd      (dma_rd),
		.dma_addr    (dma_addr),
		.dma_data    (dma_data)
	);

	initial begin
		clk_reg = 1'b0;
		forever #4 clk_reg = ~clk_reg;
	end

	always @(posedge clk_reg) begin
		cycle <= cycle + 1;
	end

	// source memory: low address byte xor page, answered in the same cycle
	always_comb begin
		if (dma_rd === 1'b1)
			dma_data = dma_addr[7:0] ^ dma_addr[15:8];
		else
			dma_data = 8'h00;
	end

	// ------------------------------
	// helpers
	// ------------------------------
	// galois lfsr, x^32+x^22+x^2+x+1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		lfsr_step = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	// one lfsr step per bit
	task automatic next_random_byte(output byte_t b);
		int i;
		for (i = 0; i < 8; i++) begin
			b[i] = lfsr[0];
			lfsr = lfsr_step(lfsr);
		end
	endtask

	task automatic report_mismatch(input string name, input logic [31:0] exp,
	                               input logic [31:0] act);
		value_errors++;
		$display("error %s expected %0h actual %0h", name, exp, act);
	endtask

	task automatic report_timeout(input string what);
		timeouts++;
		aborted = 1'b1;
		$display("timeout: %s", what);
	endtask

	task automatic reg_write(input byte_t addr, input byte_t data);
		@(negedge clk_reg);
		cpu_sel_oam = 1'b0;
		cpu_sel_reg = 1'b1;
		cpu_wr      = 1'b1;
		cpu_addr    = addr;
		cpu_di      = data;
		@(negedge clk_reg);
		cpu_sel_reg = 1'b0;
		cpu_wr      = 1'b0;
	endtask

	// read data is sampled mid low phase, well before the next edge
	task automatic bus_read(input logic oam, input byte_t addr, output byte_t data);
		@(negedge clk_reg);
		cpu_sel_oam = oam;
		cpu_sel_reg = !oam;
		cpu_wr      = 1'b0;
		cpu_addr    = addr;
		#2;
		data = cpu_do;
	endtask

	task automatic oam_write_burst(input byte_t start, input int count);
		int    k;
		byte_t a;
		byte_t b;
		for (k = 0; k < count; k++) begin
			a = start + k;
			next_random_byte(b);
			@(negedge clk_reg);
			cpu_sel_reg = 1'b0;
			cpu_sel_oam = 1'b1;
			cpu_wr      = 1'b1;
			cpu_addr    = a;
			cpu_di      = b;
			// dropped above the oam and while dma owns the port
			if (a < OAM_SIZE && !dma_pending)
				oam_model[a] = b;
		end
		@(negedge clk_reg);
		cpu_sel_oam = 1'b0;
		cpu_wr      = 1'b0;
	endtask

	// four cycles per byte, so byte n is in oam 4*(n+1) cycles after the start
	task automatic wait_dma_past(input string name, input int last_byte);
		int n;
		n = 0;
		while (cycle - dma_start_cycle < 4 * (last_byte + 1) && n < DMA_CYCLES) begin
			@(negedge clk_reg);
			n++;
		end
		if (cycle - dma_start_cycle < 4 * (last_byte + 1))
			report_timeout($sformatf("%s, dma never passed byte %02h", name, last_byte));
		// the cpu writes that follow must still fall inside the dma run
		checks++;
		if (dma_rd !== 1'b1)
			report_mismatch($sformatf("%s dma_rd", name), 1, dma_rd);
	endtask

	task automatic oam_check_range(input string name, input byte_t start, input int count);
		int    k;
		byte_t a;
		byte_t rd;
		for (k = 0; k < count; k++) begin
			a = start + k;
			bus_read(1'b1, a, rd);
			checks++;
			if (rd !== oam_model[a])
				report_mismatch($sformatf("%s oam[%02h]", name, a), oam_model[a], rd);
		end
	endtask

	task automatic wait_for_ly(input string name, input byte_t target, input int limit);
		int    n;
		byte_t v;
		n = 0;
		bus_read(1'b0, ADDR_LY, v);
		while (v !== target && n < limit) begin
			bus_read(1'b0, ADDR_LY, v);
			n++;
		end
		if (v !== target)
			report_timeout($sformatf("%s, LY never reached %02h", name, target));
	endtask

	// waits for the mode to be entered, then counts how long it lasts
	task automatic measure_mode_run(input string name, input logic [1:0] want,
	                                input int exp_len, input int limit);
		int        n;
		int        len;
		logic [1:0] prev;
		n   = 0;
		len = 0;
		@(negedge clk_reg);
		prev = mode;
		@(negedge clk_reg);
		while ((mode != want || prev == want) && n < limit) begin
			prev = mode;
			@(negedge clk_reg);
			n++;
		end
		if (mode != want || prev == want) begin
			report_timeout($sformatf("%s, mode %0d never started", name, want));
		end else begin
			while (mode == want && len < limit) begin
				len++;
				@(negedge clk_reg);
			end
			checks++;
			if (len != exp_len)
				report_mismatch(name, exp_len, len);
		end
	endtask

	// window of whole frames, so each periodic source lands a fixed count
	task automatic count_irq(input string name, input int exp_cnt, input int window);
		int n;
		int pulses;
		pulses = 0;
		for (n = 0; n < window; n++) begin
			@(negedge clk_reg);
			if (irq === 1'b1)
				pulses++;
		end
		checks++;
		if (pulses != exp_cnt)
			report_mismatch(name, exp_cnt, pulses);
	endtask

	task automatic wait_dma_done(input string name, input int exp_len, input int limit);
		int n;
		int i;
		n = 0;
		@(negedge clk_reg);
		while (dma_rd !== 1'b0 && n < limit) begin
			@(negedge clk_reg);
			n++;
		end
		if (dma_rd !== 1'b0) begin
			report_timeout($sformatf("%s, dma_rd did not drop", name));
		end else begin
			checks++;
			if (cycle - dma_start_cycle != exp_len)
				report_mismatch(name, exp_len, cycle - dma_start_cycle);
			// every byte now comes from the source model
			for (i = 0; i < OAM_SIZE; i++)
				oam_model[i] = byte_t'(i) ^ dma_page_model;
			dma_pending = 1'b0;
		end
	endtask

	// ------------------------------
	// script player
	// ------------------------------
	initial begin
		int          pc;
		logic [31:0] op;
		logic [31:0] addr;
		logic [31:0] data;
		logic [31:0] exp_v;
		logic [31:0] limit;
		byte_t       rd;
		string       name;
		reset           = 1'b1;
		cpu_sel_reg     = 1'b0;
		cpu_sel_oam     = 1'b0;
		cpu_addr        = 8'h00;
		cpu_wr          = 1'b0;
		cpu_di          = 8'h00;
		lfsr            = 32'h5fb0_f448;
		checks          = 0;
		value_errors    = 0;
		timeouts        = 0;
		dma_start_cycle = 0;
		dma_page_model  = 8'h00;
		dma_pending     = 1'b0;
		aborted         = 1'b0;
		for (pc = 0; pc < 256; pc++)
			oam_model[pc] = (pc >= OAM_SIZE) ? READ_IDLE : 8'h00;
		$readmemh("test/lcd_golden.mem", script);

		repeat (2) @(posedge clk_reg);
		@(negedge clk_reg);
		reset = 1'b0;

		// lcd off, mode 0, no irq and no dma straight out of reset
		checks++;
		if ({lcd_on, mode, irq, dma_rd} !== 5'b0_00_0_0)
			report_mismatch("reset_outputs", 5'h00, {lcd_on, mode, irq, dma_rd});

		pc = 0;
		op = script[0];
		while (op !== 0 && !aborted) begin
			addr  = script[pc*5 + 1];
			data  = script[pc*5 + 2];
			exp_v = script[pc*5 + 3];
			limit = script[pc*5 + 4];
			name  = $sformatf("cmd%0d_op%0d_addr%02h", pc, op, addr[7:0]);
			case (op)
				1: begin
					reg_write(addr[7:0], data[7:0]);
					if (addr[7:0] == ADDR_DMA) begin
						// edge of the write is the first dma cycle
						dma_start_cycle = cycle;
						dma_page_model  = data[7:0];
						dma_pending     = 1'b1;
					end
					// display enable follows LCDC bit 7 right after the write edge
					if (addr[7:0] == ADDR_LCDC) begin
						checks++;
						if (lcd_on !== data[7])
							report_mismatch($sformatf("%s lcd_on", name), data[7], lcd_on);
					end
				end
				// data column is a bit mask here
				2: begin
					bus_read(1'b0, addr[7:0], rd);
					checks++;
					if ((rd & data[7:0]) !== exp_v[7:0])
						report_mismatch(name, exp_v[7:0], rd & data[7:0]);
				end
				3: begin
					// let the dma pass these bytes first, so a leaked cpu write would stay
					if (dma_pending)
						wait_dma_past(name, addr[7:0] + data - 1);
					oam_write_burst(addr[7:0], data);
				end
				4: oam_check_range(name, addr[7:0], data);
				5: wait_for_ly(name, data[7:0], limit);
				6: wait_dma_done(name, exp_v, limit);
				7: measure_mode_run(name, data[1:0], exp_v, limit);
				8: count_irq(name, exp_v, limit);
				default: begin
					$display("golden script has a bad opcode %h at command %0d", op, pc);
					aborted = 1'b1;
					value_errors++;
				end
			endcase
			pc++;
			op = script[pc*5];
		end

		$display("checks %0d, value errors %0d, timeouts %0d, assertion failures %0d",
		         checks, value_errors, timeouts, UUT.props.assert_fails);
		if (value_errors == 0 && timeouts == 0 && UUT.props.assert_fails == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

// ==== test/lcd_controller_properties.sv ====
// ------------------------------
// lcd controller assertions: irq width, dma_rd run
// and the mode while the display is off
// ------------------------------
`timescale 1ns/1ps

module lcd_controller_properties import lcd_pkg::*; (
	input logic      clk_reg,
	input logic      reset,
	input logic      cpu_sel_reg,
	input logic      cpu_wr,
	input byte_t     cpu_addr,
	input logic      lcd_on,
	input lcd_mode_t mode,
	input logic      irq,
	input logic      dma_rd
);

	int          assert_fails = 0;
	logic        dma_write;
	logic [10:0] rd_len;

	// register write to DMA, starts or restarts a run
	assign dma_write = cpu_sel_reg && cpu_wr && (cpu_addr == ADDR_DMA);

	// cycles of the current dma_rd run
	always_ff @(posedge clk_reg) begin
		if (reset || !dma_rd)
			rd_len <= '0;
		else
			rd_len <= rd_len + 11'd1;
	end

	irq_one_cycle: assert property (@(posedge clk_reg) disable iff (reset)
		irq |=> !irq)
	else begin
		assert_fails++;
		$error("irq stayed high for two cycles");
	end

	dma_rd_needs_write: assert property (@(posedge clk_reg) disable iff (reset)
		(!dma_rd && !dma_write) |=> !dma_rd)
	else begin
		assert_fails++;
		$error("dma_rd rose without a write to DMA");
	end

	dma_rd_length: assert property (@(posedge clk_reg) disable iff (reset)
		$fell(dma_rd) |-> (rd_len == DMA_CYCLES))
	else begin
		assert_fails++;
		$error("dma_rd run was not 640 cycles");
	end

	mode_when_off: assert property (@(posedge clk_reg) disable iff (reset)
		!lcd_on |-> (mode == MODE_HBLANK))
	else begin
		assert_fails++;
		$error("mode not hblank with the lcd off");
	end

endmodule

bind lcd_controller lcd_controller_properties props (
	.clk_reg     (clk_reg),
	.reset       (reset),
	.cpu_sel_reg (cpu_sel_reg),
	.cpu_wr      (cpu_wr),
	.cpu_addr    (cpu_addr),
	.lcd_on      (lcd_on),
	.mode        (mode),
	.irq         (irq),
	.dma_rd      (dma_rd)
);

// ==== src/lcd_controller.sv ====
// ------------------------------
// lcd controller top: cpu register file, line timing,
// stat interrupts and oam dma around a 160 byte oam
// ------------------------------
`timescale 1ns/1ps

module lcd_controller import lcd_pkg::*; (
	input  logic      clk_reg,
	input  logic      reset,

	// cpu register and oam bus
	input  logic      cpu_sel_reg,
	input  logic      cpu_sel_oam,
	input  byte_t     cpu_addr,
	input  logic      cpu_wr,
	input  byte_t     cpu_di,
	output byte_t     cpu_do,

	// status towards the system
	output logic      lcd_on,
	output lcd_mode_t mode,
	output logic      irq,

	// dma source bus
	output logic      dma_rd,
	output logic [15:0] dma_addr,
	input  byte_t     dma_data
);

	// register file <-> timing
	logic [3:0] stat_ie;
	line_t      lyc;
	line_t      ly;
	logic       lyc_match;

	// register file -> dma engine
	byte_t      dma_page;
	logic       dma_start;

	// dma engine -> oam
	logic       dma_active;
	logic       dma_wr;
	oam_addr_t  dma_oam_addr;

	// read data of the two cpu targets
	byte_t      reg_do;
	byte_t      oam_do;

	lcd_regs regs (
		.clk_reg     (clk_reg),
		.reset       (reset),
		.cpu_sel_reg (cpu_sel_reg),
		.cpu_wr      (cpu_wr),
		.cpu_addr    (cpu_addr),
		.cpu_di      (cpu_di),
		.ly          (ly),
		.mode        (mode),
		.lyc_match   (lyc_match),
		.reg_do      (reg_do),
		.lcd_on      (lcd_on),
		.stat_ie     (stat_ie),
		.lyc         (lyc),
		.dma_page    (dma_page),
		.dma_start   (dma_start)
	);

	lcd_timing timing (
		.clk_reg   (clk_reg),
		.reset     (reset),
		.lcd_on    (lcd_on),
		.stat_ie   (stat_ie),
		.lyc       (lyc),
		.ly        (ly),
		.mode      (mode),
		.lyc_match (lyc_match),
		.irq       (irq)
	);

	oam_dma dma (
		.clk_reg      (clk_reg),
		.reset        (reset),
		.dma_start    (dma_start),
		.dma_page     (dma_page),
		.dma_active   (dma_active),
		.dma_addr     (dma_addr),
		.dma_wr       (dma_wr),
		.dma_oam_addr (dma_oam_addr)
	);

	oam_ram oam (
		.clk_reg      (clk_reg),
		.cpu_sel_oam  (cpu_sel_oam),
		.cpu_wr       (cpu_wr),
		.cpu_addr     (cpu_addr),
		.cpu_di       (cpu_di),
		.dma_active   (dma_active),
		.dma_wr       (dma_wr),
		.dma_oam_addr (dma_oam_addr),
		.dma_data     (dma_data),
		.oam_do       (oam_do)
	);

	// the source bus is read for the whole dma run
	assign dma_rd = dma_active;

	// oam select wins, open bus reads all ones
	assign cpu_do = cpu_sel_oam ? oam_do :
	                cpu_sel_reg ? reg_do :
	                READ_IDLE;

endmodule

// ==== oam/oam_ram.sv ====
// ------------------------------
// 160 byte object attribute memory,
// dma owns the write port while active
// ------------------------------
`timescale 1ns/1ps

module oam_ram import lcd_pkg::*; (
	input  logic      clk_reg,
	input  logic      cpu_sel_oam,
	input  logic      cpu_wr,
	input  byte_t     cpu_addr,
	input  byte_t     cpu_di,
	input  logic      dma_active,
	input  logic      dma_wr,
	input  oam_addr_t dma_oam_addr,
	input  byte_t     dma_data,

	output byte_t     oam_do
);

	byte_t     mem [0:OAM_SIZE-1];

	oam_addr_t wr_addr;
	byte_t     wr_data;
	logic      wr_en;

	// write port mux, cpu writes are dropped during dma
	assign wr_addr = dma_active ? dma_oam_addr : cpu_addr;
	assign wr_data = dma_active ? dma_data : cpu_di;
	assign wr_en   = dma_active ? dma_wr : (cpu_sel_oam && cpu_wr);

	always_ff @(posedge clk_reg) begin
		// nothing mapped from 160 upward
		if (wr_en && (wr_addr < OAM_SIZE))
			mem[wr_addr] <= wr_data;
	end

	// cpu read path, zero cycles
	assign oam_do = (cpu_addr < OAM_SIZE) ? mem[cpu_addr] : READ_IDLE;

endmodule

// ==== oam/oam_dma.sv ====
// ------------------------------
// oam dma engine: 160 bytes in 640 cycles,
// source address and oam write strobe
// ------------------------------
`timescale 1ns/1ps

module oam_dma import lcd_pkg::*; (
	input  logic        clk_reg,
	input  logic        reset,
	input  logic        dma_start,
	input  byte_t       dma_page,

	output logic        dma_active,
	output logic [15:0] dma_addr,
	output logic        dma_wr,
	output oam_addr_t   dma_oam_addr
);

	// four cycles per byte
	dma_cnt_t dma_cnt;

	always_ff @(posedge clk_reg) begin
		if (reset) begin
			dma_active <= 1'b0;
			dma_cnt    <= '0;
		end else if (dma_start) begin
			// a new write restarts from byte 0
			dma_active <= 1'b1;
			dma_cnt    <= '0;
		end else if (dma_active) begin
			if (dma_cnt == DMA_CYCLES - 10'd1) begin
				dma_active <= 1'b0;
				dma_cnt    <= '0;
			end else begin
				dma_cnt <= dma_cnt + 10'd1;
			end
		end
	end

	// byte index is count / 4
	assign dma_oam_addr = dma_cnt[9:2];

	// page in the high byte, index in the low byte
	assign dma_addr = {dma_page, dma_oam_addr};

	// source data is combinational, latch it into oam at phase 2
	assign dma_wr = dma_active && (dma_cnt[1:0] == DMA_WR_PHASE);

endmodule

// ==== src/lcd_timing.sv ====
// ------------------------------
// line/frame counters, STAT mode decode,
// LYC compare and STAT interrupt pulse
// ------------------------------
`timescale 1ns/1ps

module lcd_timing import lcd_pkg::*; (
	input  logic       clk_reg,
	input  logic       reset,
	input  logic       lcd_on,
	// STAT bits 6:3 -> lyc, oam, vblank, hblank
	input  logic [3:0] stat_ie,
	input  line_t      lyc,

	output line_t      ly,
	output lcd_mode_t  mode,
	output logic       lyc_match,
	output logic       irq
);

	// cycle within the current line, 0..455
	hcnt_t h_cnt;

	logic  vblank;
	logic  irq_lyc;
	logic  irq_oam;
	logic  irq_vblank;
	logic  irq_hblank;

	// ------------------------------
	// counters
	// ------------------------------
	always_ff @(posedge clk_reg) begin
		if (reset || !lcd_on) begin
			// parked while the display is off
			h_cnt <= LCD_OFF_HCNT;
			ly    <= '0;
		end else if (h_cnt == LINE_LAST) begin
			h_cnt <= '0;
			// new line, wrap after the last vblank line
			if (ly == FRAME_LAST)
				ly <= '0;
			else
				ly <= ly + 8'd1;
		end else begin
			h_cnt <= h_cnt + 9'd1;
		end
	end

	// ------------------------------
	// mode decode
	// ------------------------------
	assign vblank = (ly >= VBLANK_LINE);

	always_comb begin
		if (!lcd_on)
			mode = MODE_HBLANK;
		else if (vblank)
			mode = MODE_VBLANK;
		else if (h_cnt < OAM_LEN)
			mode = MODE_OAM;
		else if (h_cnt < HBLANK_START)
			mode = MODE_XFER;
		else
			mode = MODE_HBLANK;
	end

	assign lyc_match = (ly == lyc);

	// ------------------------------
	// stat interrupt sources
	// ------------------------------
	// coincidence tested a couple of cycles into the line
	assign irq_lyc    = stat_ie[3] && (h_cnt == LYC_IRQ_HCNT) && lyc_match;
	// start of the oam phase
	assign irq_oam    = stat_ie[2] && (h_cnt == '0);
	// last cycle of line 143, vblank begins next edge
	assign irq_vblank = stat_ie[1] && (h_cnt == LINE_LAST) && (ly == VBLANK_LINE - 8'd1);
	// fixed hblank start
	assign irq_hblank = stat_ie[0] && (h_cnt == HBLANK_START);

	// each source hits a different h_cnt, so the pulse is one cycle wide
	always_ff @(posedge clk_reg) begin
		if (reset)
			irq <= 1'b0;
		else
			irq <= irq_lyc || irq_oam || irq_vblank || irq_hblank;
	end

endmodule

// ==== src/lcd_regs.sv ====
// ------------------------------
// cpu register file 0x40-0x4b: write decode, reset values,
// read mux with live STAT and LY
// ------------------------------
`timescale 1ns/1ps

module lcd_regs import lcd_pkg::*; (
	input  logic       clk_reg,
	input  logic       reset,
	input  logic       cpu_sel_reg,
	input  logic       cpu_wr,
	input  byte_t      cpu_addr,
	input  byte_t      cpu_di,

	// live status from the timing block
	input  line_t      ly,
	input  lcd_mode_t  mode,
	input  logic       lyc_match,

	output byte_t      reg_do,
	output logic       lcd_on,
	output logic [3:0] stat_ie,
	output line_t      lyc,
	output byte_t      dma_page,
	output logic       dma_start
);

	byte_t lcdc;
	byte_t scy;
	byte_t scx;
	byte_t bgp;
	byte_t obp0;
	byte_t obp1;
	byte_t wy;
	byte_t wx;

	logic  reg_wr;

	// write strobe, single cycle, no wait state
	assign reg_wr = cpu_sel_reg && cpu_wr;

	// ------------------------------
	// write decode
	// ------------------------------
	always_ff @(posedge clk_reg) begin
		if (reset) begin
			// lcd starts off
			lcdc     <= '0;
			stat_ie  <= '0;
			scy      <= '0;
			scx      <= '0;
			lyc      <= '0;
			dma_page <= '0;
			bgp      <= BGP_RESET;
			obp0     <= OBP_RESET;
			obp1     <= OBP_RESET;
			wy       <= '0;
			wx       <= '0;
		end else if (reg_wr) begin
			case (cpu_addr)
				ADDR_LCDC: lcdc     <= cpu_di;
				// only the enable bits 6:3 are writable
				ADDR_STAT: stat_ie  <= cpu_di[6:3];
				ADDR_SCY:  scy      <= cpu_di;
				ADDR_SCX:  scx      <= cpu_di;
				// LY is read only, write dropped
				ADDR_LYC:  lyc      <= cpu_di;
				ADDR_DMA:  dma_page <= cpu_di;
				ADDR_BGP:  bgp      <= cpu_di;
				ADDR_OBP0: obp0     <= cpu_di;
				ADDR_OBP1: obp1     <= cpu_di;
				ADDR_WY:   wy       <= cpu_di;
				ADDR_WX:   wx       <= cpu_di;
				default: ;
			endcase
		end
	end

	// kicks the dma engine on the same edge that loads dma_page
	assign dma_start = reg_wr && (cpu_addr == ADDR_DMA);

	// display enable is LCDC bit 7
	assign lcd_on = lcdc[7];

	// ------------------------------
	// read mux, combinational from the address
	// ------------------------------
	always_comb begin
		case (cpu_addr)
			ADDR_LCDC: reg_do = lcdc;
			// bit 7 always reads one
			ADDR_STAT: reg_do = {1'b1, stat_ie, lyc_match, mode};
			ADDR_SCY:  reg_do = scy;
			ADDR_SCX:  reg_do = scx;
			ADDR_LY:   reg_do = ly;
			ADDR_LYC:  reg_do = lyc;
			ADDR_DMA:  reg_do = dma_page;
			ADDR_BGP:  reg_do = bgp;
			ADDR_OBP0: reg_do = obp0;
			ADDR_OBP1: reg_do = obp1;
			ADDR_WY:   reg_do = wy;
			ADDR_WX:   reg_do = wx;
			// unmapped
			default:   reg_do = READ_IDLE;
		endcase
	end

endmodule

// ==== common/lcd_pkg.sv ====
// ------------------------------
// lcd controller shared definitions: widths, register map,
// line/frame timing constants and the STAT mode encoding
// ------------------------------
package lcd_pkg;

	// data and counter widths
	typedef logic [7:0] byte_t;
	typedef logic [8:0] hcnt_t;
	typedef logic [7:0] line_t;
	typedef logic [9:0] dma_cnt_t;
	typedef logic [7:0] oam_addr_t;

	// STAT mode field, bits 1:0
	typedef enum logic [1:0] {
		MODE_HBLANK = 2'd0,
		MODE_VBLANK = 2'd1,
		MODE_OAM    = 2'd2,
		MODE_XFER   = 2'd3
	} lcd_mode_t;

	// ------------------------------
	// register map, low byte of 0xff4x
	// ------------------------------
	localparam byte_t ADDR_LCDC = 8'h40;
	localparam byte_t ADDR_STAT = 8'h41;
	localparam byte_t ADDR_SCY  = 8'h42;
	localparam byte_t ADDR_SCX  = 8'h43;
	localparam byte_t ADDR_LY   = 8'h44;
	localparam byte_t ADDR_LYC  = 8'h45;
	localparam byte_t ADDR_DMA  = 8'h46;
	localparam byte_t ADDR_BGP  = 8'h47;
	localparam byte_t ADDR_OBP0 = 8'h48;
	localparam byte_t ADDR_OBP1 = 8'h49;
	localparam byte_t ADDR_WY   = 8'h4a;
	localparam byte_t ADDR_WX   = 8'h4b;

	// ------------------------------
	// line and frame timing
	// ------------------------------
	localparam hcnt_t LINE_LAST    = 9'd455;
	localparam line_t FRAME_LAST   = 8'd153;
	localparam line_t VBLANK_LINE  = 8'd144;
	localparam hcnt_t OAM_LEN      = 9'd80;
	localparam hcnt_t XFER_LEN     = 9'd160;
	// fixed hblank start, no extra fetch time per line
	localparam hcnt_t HBLANK_START = OAM_LEN + XFER_LEN;
	localparam hcnt_t LCD_OFF_HCNT = 9'd4;
	localparam hcnt_t LYC_IRQ_HCNT = 9'd2;

	// oam and dma
	localparam oam_addr_t OAM_SIZE     = 8'd160;
	localparam dma_cnt_t  DMA_CYCLES   = 10'd640;
	localparam logic [1:0] DMA_WR_PHASE = 2'd2;

	// reset and idle values
	localparam byte_t BGP_RESET = 8'hfc;
	localparam byte_t OBP_RESET = 8'hff;
	localparam byte_t READ_IDLE = 8'hff;

endpackage
